// File: vendPkg.sv
package vendPkg;

    localparam int itemCount = 9;    // item select buttons
    localparam int coinCount = 6;    // coin inputs
    localparam int moneyBits = 9;    // enough for 500 cents
    localparam int numBits = 14;     // display number, up to 9999

    typedef logic [moneyBits-1:0] moneyT;    // money or price in cents

    // one digit of the display, active low, bit 0 is the point
    typedef logic [7:0] segT;

    localparam moneyT maxMoney = 9'd500;    // money ceiling

    // coin values in cents, same order as the coin inputs
    localparam moneyT coinValue [coinCount] = '{
        9'd5,      // nickel
        9'd10,     // dime
        9'd25,     // quarter
        9'd50,     // half dollar
        9'd100,    // dollar
        9'd500     // five dollars
    };

    localparam segT segDigit [10] = '{
        8'b1000_0001,    // 0
        8'b1111_0011,    // 1
        8'b0100_1001,    // 2
        8'b0110_0001,    // 3
        8'b0011_0011,    // 4
        8'b0010_0101,    // 5
        8'b0000_0101,    // 6
        8'b1111_0001,    // 7
        8'b0000_0001,    // 8
        8'b0010_0001     // 9
    };

    localparam segT segMinus = 8'b0111_1111;    // middle bar only

endpackage

// File: vendControl.sv
`timescale 1ns/1ps

module vendControl #(
    parameter vendPkg::moneyT prices [vendPkg::itemCount] = '{default: '0}
) (
    input  logic                          A1,
    input  logic                          A2,
    input  logic [vendPkg::itemCount-1:0] item,
    input  logic [vendPkg::coinCount-1:0] coin,
    input  logic                          cancel,
    output logic [vendPkg::itemCount-1:0] haveFunds,
    output logic [vendPkg::itemCount-1:0] soldOut,
    output logic [vendPkg::itemCount-1:0] dispensed,
    output logic                          showLoad,
    output logic [vendPkg::numBits-1:0]   showNumber,
    output logic                          showDecimal,
    output logic                          showNegative
);

    typedef logic [$clog2(vendPkg::itemCount)-1:0] itemIdxT;
    typedef logic [$clog2(vendPkg::coinCount)-1:0] coinIdxT;
    typedef logic [vendPkg::numBits-1:0] numT;

    logic [vendPkg::itemCount-1:0] itemPrev;    // last button samples
    logic [vendPkg::coinCount-1:0] coinPrev;
    logic                          cancelPrev;

    logic [vendPkg::itemCount-1:0] itemRise;
    logic [vendPkg::coinCount-1:0] coinRise;
    logic                          cancelRise;

    itemIdxT                     itemIdx;     // lowest rising item
    coinIdxT                     coinIdx;     // lowest rising coin
    vendPkg::moneyT              selPrice;
    logic [vendPkg::moneyBits:0] coinSum;     // one extra bit for the overflow check

    vendPkg::moneyT money;
    vendPkg::moneyT moneyNext;
    logic           dispValid;
    logic           dispValidNext;
    itemIdxT        dispIdx;
    itemIdxT        dispIdxNext;
    logic           loadNext;
    numT            numNext;
    logic           decNext;
    logic           negNext;

    assign itemRise = item & ~itemPrev;
    assign coinRise = coin & ~coinPrev;
    assign cancelRise = cancel & ~cancelPrev;

    always_comb begin
        itemIdx = '0;
        for (int i = vendPkg::itemCount - 1; i >= 0; i--) begin
            if (itemRise[i]) begin
                itemIdx = itemIdxT'(i);    // ends on the lowest index
            end
        end
        coinIdx = '0;
        for (int i = vendPkg::coinCount - 1; i >= 0; i--) begin
            if (coinRise[i]) begin
                coinIdx = coinIdxT'(i);
            end
        end
    end

    assign selPrice = prices[itemIdx];
    assign coinSum = {1'b0, money} + {1'b0, vendPkg::coinValue[coinIdx]};

    // items first, then coins, then cancel
    always_comb begin
        moneyNext = money;
        dispValidNext = dispValid;
        dispIdxNext = dispIdx;
        loadNext = 1'b0;
        numNext = '0;
        decNext = 1'b1;
        negNext = 1'b0;
        if (|itemRise) begin
            if (money == '0) begin
                loadNext = 1'b1;    // price query
                numNext = numT'(selPrice);
            end else if (selPrice != '0) begin
                loadNext = 1'b1;
                if (money >= selPrice) begin
                    numNext = numT'(money - selPrice);    // change, money kept
                    dispValidNext = 1'b1;
                    dispIdxNext = itemIdx;
                end else begin
                    numNext = numT'(selPrice - money);    // amount still missing
                    negNext = 1'b1;
                end
            end
        end else if (|coinRise) begin
            if (coinSum <= {1'b0, vendPkg::maxMoney}) begin
                moneyNext = coinSum[vendPkg::moneyBits-1:0];
                loadNext = 1'b1;
                numNext = numT'(coinSum);
            end
        end else if (cancelRise) begin
            moneyNext = '0;
            dispValidNext = 1'b0;
            loadNext = 1'b1;
            decNext = 1'b0;    // plain 0000
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            itemPrev <= '0;
            coinPrev <= '0;
            cancelPrev <= 1'b0;
            money <= '0;
            dispValid <= 1'b0;
            dispIdx <= '0;
            showLoad <= 1'b0;
        end else begin
            itemPrev <= item;
            coinPrev <= coin;
            cancelPrev <= cancel;
            money <= moneyNext;
            dispValid <= dispValidNext;
            dispIdx <= dispIdxNext;
            showLoad <= loadNext;
        end
    end

    always_ff @(posedge A1) begin
        if (loadNext) begin
            showNumber <= numNext;
            showDecimal <= decNext;
            showNegative <= negNext;
        end
    end

    always_comb begin
        for (int i = 0; i < vendPkg::itemCount; i++) begin
            haveFunds[i] = (prices[i] != '0) && (money >= prices[i]);
            soldOut[i] = (prices[i] == '0);
            dispensed[i] = dispValid && (dispIdx == itemIdxT'(i));
        end
    end

endmodule

// File: displayBuffer.sv
`timescale 1ns/1ps

module displayBuffer (
    input  logic                        A1,
    input  logic                        A2,
    input  logic                        showLoad,
    input  logic [vendPkg::numBits-1:0] showNumber,
    input  logic                        showDecimal,
    input  logic                        showNegative,
    output vendPkg::segT                digit0Seg,
    output vendPkg::segT                digit1Seg,
    output vendPkg::segT                digit2Seg,
    output vendPkg::segT                digit3Seg
);

    logic [15:0]  bcd;     // four decimal digits, digit3 on top
    vendPkg::segT seg0;
    vendPkg::segT seg1;
    vendPkg::segT seg2;
    vendPkg::segT seg3;

    function automatic vendPkg::segT digitPattern(input logic [3:0] d);
        // codes above 9 only appear for numbers past 9999, shown blank
        return (d > 4'd9) ? '1 : vendPkg::segDigit[d];
    endfunction

    // shift and add three, one input bit per step
    always_comb begin
        bcd = '0;
        for (int i = vendPkg::numBits - 1; i >= 0; i--) begin
            for (int d = 0; d < 4; d++) begin
                if (bcd[4*d +: 4] > 4'd4) begin
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
                end
            end
            bcd = {bcd[14:0], showNumber[i]};
        end
    end

    always_comb begin
        seg0 = digitPattern(bcd[3:0]);
        seg1 = digitPattern(bcd[7:4]);
        seg2 = digitPattern(bcd[11:8]);
        if (showDecimal) begin
            seg2[0] = 1'b0;    // point lights, dollars.cents
        end
        seg3 = showNegative ? vendPkg::segMinus : digitPattern(bcd[15:12]);
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            digit0Seg <= vendPkg::segDigit[0];
            digit1Seg <= vendPkg::segDigit[0];
            digit2Seg <= vendPkg::segDigit[0];
            digit3Seg <= vendPkg::segDigit[0];
        end else if (showLoad) begin
            digit0Seg <= seg0;    // newest request wins
            digit1Seg <= seg1;
            digit2Seg <= seg2;
            digit3Seg <= seg3;
        end
    end

endmodule

// File: digitScan.sv
`timescale 1ns/1ps

module digitScan #(
    parameter int ScanDivBits = 17
) (
    input  logic         A1,
    input  logic         A2,
    input  vendPkg::segT digit0Seg,
    input  vendPkg::segT digit1Seg,
    input  vendPkg::segT digit2Seg,
    input  vendPkg::segT digit3Seg,
    output logic [3:0]   anx,
    output vendPkg::segT value
);

    logic [ScanDivBits+1:0] scanCount;    // free running divider
    logic [1:0]             digitSel;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    assign digitSel = scanCount[ScanDivBits+1 -: 2];    // top two bits
    assign anx = ~(4'b0001 << digitSel);                // one anode low

    always_comb begin
        case (digitSel)
            2'd0: value = digit0Seg;
            2'd1: value = digit1Seg;
            2'd2: value = digit2Seg;
            default: value = digit3Seg;    // leftmost digit
        endcase
    end

endmodule

// File: vendingMachine.sv
`timescale 1ns/1ps

module vendingMachine #(
    parameter vendPkg::moneyT prices [vendPkg::itemCount] = '{
        9'd100,    // A1
        9'd0,      // A2, out of stock
        9'd125,    // A3
        9'd175,    // B1
        9'd225,    // B2
        9'd250,    // B3
        9'd100,    // C1
        9'd325,    // C2
        9'd375     // C3
    },
    parameter int ScanDivBits = 17
) (
    input  logic                          A1,
    input  logic                          A2,
    input  logic [vendPkg::itemCount-1:0] item,
    input  logic [vendPkg::coinCount-1:0] coin,
    input  logic                          cancel,
    output logic [vendPkg::itemCount-1:0] haveFunds,
    output logic [vendPkg::itemCount-1:0] soldOut,
    output logic [vendPkg::itemCount-1:0] dispensed,
    output logic [3:0]                    anx,
    output vendPkg::segT                  value
);

    logic                        showLoad;
    logic [vendPkg::numBits-1:0] showNumber;
    logic                        showDecimal;
    logic                        showNegative;
    vendPkg::segT                digit0Seg;
    vendPkg::segT                digit1Seg;
    vendPkg::segT                digit2Seg;
    vendPkg::segT                digit3Seg;

    vendControl #(
        .prices(prices)
    ) u_control (
        .A1(A1),
        .A2(A2),
        .item(item),
        .coin(coin),
        .cancel(cancel),
        .haveFunds(haveFunds),
        .soldOut(soldOut),
        .dispensed(dispensed),
        .showLoad(showLoad),
        .showNumber(showNumber),
        .showDecimal(showDecimal),
        .showNegative(showNegative)
    );

    displayBuffer u_buffer (
        .A1(A1),
        .A2(A2),
        .showLoad(showLoad),
        .showNumber(showNumber),
        .showDecimal(showDecimal),
        .showNegative(showNegative),
        .digit0Seg(digit0Seg),
        .digit1Seg(digit1Seg),
        .digit2Seg(digit2Seg),
        .digit3Seg(digit3Seg)
    );

    digitScan #(
        .ScanDivBits(ScanDivBits)
    ) u_scan (
        .A1(A1),
        .A2(A2),
        .digit0Seg(digit0Seg),
        .digit1Seg(digit1Seg),
        .digit2Seg(digit2Seg),
        .digit3Seg(digit3Seg),
        .anx(anx),
        .value(value)
    );

endmodule

// File: vendCheck_sva.sv
`timescale 1ns/1ps

module vendCheck #(
    parameter vendPkg::moneyT prices [vendPkg::itemCount] = '{default: '0}
) (
    input logic                          A1,
    input logic                          A2,
    input logic [3:0]                    anx,
    input logic [vendPkg::itemCount-1:0] haveFunds,
    input logic [vendPkg::itemCount-1:0] soldOut,
    input logic [vendPkg::itemCount-1:0] dispensed,
    input vendPkg::moneyT                money
);

    int failCount = 0;    // assertion failures so far

    logic [vendPkg::itemCount-1:0] zeroMask;     // items priced zero
    logic [vendPkg::itemCount-1:0] fundsMask;    // items the money can buy

    always_comb begin
        for (int i = 0; i < vendPkg::itemCount; i++) begin
            zeroMask[i] = (prices[i] == '0);
            fundsMask[i] = (prices[i] != '0) && (money >= prices[i]);
        end
    end

    anxOneLow: assert property (@(posedge A1) disable iff (A2) $onehot(~anx))
        else begin
            $error("anode enables do not have exactly one low bit");
            failCount++;
        end

    dispensedOneHot: assert property (@(posedge A1) disable iff (A2) $onehot0(dispensed))
        else begin
            $error("more than one dispense LED lit");
            failCount++;
        end

    soldOutMatch: assert property (@(posedge A1) disable iff (A2) soldOut == zeroMask)
        else begin
            $error("sold out LEDs do not follow the zero prices");
            failCount++;
        end

    fundsMatch: assert property (@(posedge A1) disable iff (A2) haveFunds == fundsMask)
        else begin
            $error("green LEDs do not follow the money");
            failCount++;
        end

    moneyCeiling: assert property (@(posedge A1) disable iff (A2) money <= vendPkg::maxMoney)
        else begin
            $error("money went past the ceiling");
            failCount++;
        end

endmodule

bind vendingMachine vendCheck #(
    .prices(prices)
) u_check (
    .A1(A1),
    .A2(A2),
    .anx(anx),
    .haveFunds(haveFunds),
    .soldOut(soldOut),
    .dispensed(dispensed),
    .money(u_control.money)
);

// File: tbVending.sv
`timescale 1ns/1ps

module tbVending;

    localparam vendPkg::moneyT priceList [vendPkg::itemCount] = '{
        9'd100, 9'd0, 9'd125, 9'd175, 9'd225, 9'd250, 9'd100, 9'd325, 9'd375
    };
    localparam logic [3:0] anxOrder [4] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};
    localparam int scanWait = 64;    // cycles allowed per digit

    logic                          A1;
    logic                          A2;
    logic [vendPkg::itemCount-1:0] item;
    logic [vendPkg::coinCount-1:0] coin;
    logic                          cancel;
    logic [vendPkg::itemCount-1:0] haveFunds;
    logic [vendPkg::itemCount-1:0] soldOut;
    logic [vendPkg::itemCount-1:0] dispensed;
    logic [3:0]                    anx;
    vendPkg::segT                  value;

    int          errCount;
    int          testStartErr;
    int          testCount;
    int          failedTests;
    int          svaFails;
    logic [31:0] rngState;
    int          modelMoney;      // reference model state
    int          modelDisp;       // -1 when nothing dispensed
    int          shownNumber;
    bit          shownDecimal;
    bit          shownNegative;

    vendingMachine #(
        .ScanDivBits(2)
    ) u_dut (
        .A1(A1),
        .A2(A2),
        .item(item),
        .coin(coin),
        .cancel(cancel),
        .haveFunds(haveFunds),
        .soldOut(soldOut),
        .dispensed(dispensed),
        .anx(anx),
        .value(value)
    );

    always #50 A1 = ~A1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected pattern of one digit from the displayed number
    function automatic vendPkg::segT expectedSeg(input int pos);
        int           digit;
        vendPkg::segT seg;
        digit = shownNumber;
        for (int i = 0; i < pos; i++) begin
            digit = digit / 10;
        end
        seg = vendPkg::segDigit[digit % 10];
        if (pos == 2 && shownDecimal) begin
            seg[0] = 1'b0;
        end
        if (pos == 3 && shownNegative) begin
            seg = vendPkg::segMinus;
        end
        return seg;
    endfunction

    task automatic reportMismatch(input string what, input logic [8:0] got,
                                  input logic [8:0] expected);
        $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, expected);
        errCount++;
    endtask

    // level high for two cycles, then low for two
    task automatic pressButtons(input logic [vendPkg::itemCount-1:0] itemMask,
                                input logic [vendPkg::coinCount-1:0] coinMask,
                                input logic cancelLevel);
        @(posedge A1);
        #1;
        item = itemMask;
        coin = coinMask;
        cancel = cancelLevel;
        repeat (2) @(posedge A1);
        #1;
        item = '0;
        coin = '0;
        cancel = 1'b0;
        repeat (2) @(posedge A1);
    endtask

    task automatic itemRule(input int idx);
        int price;
        price = priceList[idx];
        if (modelMoney == 0) begin
            shownNumber = price;    // price query
            shownDecimal = 1'b1;
            shownNegative = 1'b0;
        end else if (price != 0) begin
            shownDecimal = 1'b1;
            shownNegative = (modelMoney < price);
            shownNumber = shownNegative ? price - modelMoney : modelMoney - price;
            if (!shownNegative) begin
                modelDisp = idx;
            end
        end
    endtask

    task automatic coinRule(input int idx);
        if (modelMoney + vendPkg::coinValue[idx] <= vendPkg::maxMoney) begin
            modelMoney = modelMoney + vendPkg::coinValue[idx];
            shownNumber = modelMoney;
            shownDecimal = 1'b1;
            shownNegative = 1'b0;
        end
    endtask

    task automatic cancelRule();
        modelMoney = 0;
        modelDisp = -1;
        shownNumber = 0;
        shownDecimal = 1'b0;
        shownNegative = 1'b0;
    endtask

    task automatic selectItem(input int idx);
        pressButtons(9'(1) << idx, '0, 1'b0);
        itemRule(idx);
    endtask

    task automatic insertCoin(input int idx);
        pressButtons('0, 6'(1) << idx, 1'b0);
        coinRule(idx);
    endtask

    task automatic pressCancel();
        pressButtons('0, '0, 1'b1);
        cancelRule();
    endtask

    // wait for each anode in turn and compare the segment byte
    task automatic checkDisplay(input string what);
        int           w;
        bit           found;
        vendPkg::segT expected;
        for (int d = 0; d < 4; d++) begin
            found = 1'b0;
            for (w = 0; w < scanWait && !found; w++) begin
                @(negedge A1);
                found = (anx == anxOrder[d]);
            end
            if (!found) begin
                $display("display scan never reached digit %0d during %s", d, what);
                errCount++;
            end else begin
                expected = expectedSeg(d);
                assert (value == expected)
                    else reportMismatch($sformatf("%s digit %0d", what, d), 9'(value),
                                        9'(expected));
            end
        end
    endtask

    task automatic checkLeds(input string what);
        logic [vendPkg::itemCount-1:0] expFunds;
        logic [vendPkg::itemCount-1:0] expSold;
        logic [vendPkg::itemCount-1:0] expDisp;
        for (int i = 0; i < vendPkg::itemCount; i++) begin
            expSold[i] = (priceList[i] == 0);
            expFunds[i] = (priceList[i] != 0) && (modelMoney >= priceList[i]);
            expDisp[i] = (modelDisp == i);
        end
        assert (haveFunds == expFunds)
            else reportMismatch({what, " haveFunds"}, haveFunds, expFunds);
        assert (soldOut == expSold)
            else reportMismatch({what, " soldOut"}, soldOut, expSold);
        assert (dispensed == expDisp)
            else reportMismatch({what, " dispensed"}, dispensed, expDisp);
    endtask

    task automatic checkAll(input string what);
        checkDisplay(what);
        checkLeds(what);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount == testStartErr) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errCount - testStartErr);
        end
        testStartErr = errCount;
    endtask

    initial begin
        logic [vendPkg::itemCount-1:0] fundsBefore;
        A1 = 1'b0;
        A2 = 1'b1;
        item = '0;
        coin = '0;
        cancel = 1'b0;
        errCount = 0;
        testStartErr = 0;
        testCount = 0;
        failedTests = 0;
        rngState = 32'hac077f5d;
        cancelRule();    // reset shows plain 0000
        repeat (16) @(posedge A1);
        #1;
        A2 = 1'b0;

        checkAll("after reset");
        for (int i = 0; i < vendPkg::itemCount; i++) begin
            selectItem(i);
            checkAll($sformatf("price of item %0d", i));
        end
        finishTest("price query");

        for (int n = 0; n < 12; n++) begin
            rngState = xorshift(rngState);
            insertCoin(int'(rngState % vendPkg::coinCount));
            checkAll($sformatf("coin %0d", n));
        end
        fundsBefore = haveFunds;
        insertCoin(5);    // five dollars always passes the ceiling here
        checkAll("rejected coin");
        assert (haveFunds == fundsBefore)
            else reportMismatch("haveFunds after rejected coin", haveFunds, fundsBefore);
        finishTest("coins and ceiling");

        pressCancel();
        insertCoin(4);
        insertCoin(4);
        insertCoin(2);
        checkAll("two dollars twenty five");
        selectItem(0);
        checkAll("buy item 0");
        selectItem(4);
        checkAll("buy item 4");
        finishTest("purchase");

        selectItem(8);
        checkAll("short on item 8");
        finishTest("shortfall");

        pressCancel();
        checkAll("cancel");
        finishTest("cancel");

        insertCoin(4);
        pressButtons(9'b0_0000_0001, 6'b01_0000, 1'b0);
        itemRule(0);    // the coin is ignored
        checkAll("item and coin together");
        finishTest("priority");

        svaFails = u_dut.u_check.failCount;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testCount, failedTests, errCount, svaFails);
        if (errCount == 0 && svaFails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim.f
vendPkg.sv
vendControl.sv
displayBuffer.sv
digitScan.sv
vendingMachine.sv
vendCheck_sva.sv
tbVending.sv

// File: Makefile
TOP = tbVending

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
